// ==== design/execPkg.sv ====
`default_nettype none

package execPkg;

  localparam int unsigned queueDepth = 4;
  localparam int unsigned outCreditInit = 4;
  localparam int unsigned qPtrWidth = $clog2(queueDepth);
  localparam int unsigned qCountWidth = $clog2(queueDepth + 1);
  localparam int unsigned creditWidth = $clog2(outCreditInit + 1);

  typedef logic [qPtrWidth-1:0] qPtr_t;
  typedef logic [qCountWidth-1:0] qCount_t;
  typedef logic [creditWidth-1:0] creditCnt_t;

  typedef enum logic [1:0] {lsl = 2'b00, lsr = 2'b01, asr = 2'b10, ror = 2'b11} shiftKind_t;

  typedef enum logic [1:0] {
    immShift  = 2'b00,
    regShift  = 2'b01,
    memOffset = 2'b10, // Load/store offset
    rotImm    = 2'b11
  } operandForm_t;

  // ARM data-processing opcodes
  typedef enum logic [3:0] {
    opAnd = 4'h0, opEor = 4'h1, opSub = 4'h2, opRsb = 4'h3,
    opAdd = 4'h4, opAdc = 4'h5, opSbc = 4'h6, opRsc = 4'h7,
    opTst = 4'h8, opTeq = 4'h9, opCmp = 4'hA, opCmn = 4'hB,
    opOrr = 4'hC, opMov = 4'hD, opBic = 4'hE, opMvn = 4'hF
  } aluOp_t;

  // Instruction bits [11:0] read three ways
  typedef union packed {
    struct packed {
      logic [4:0] amount;   // [11:7]
      shiftKind_t kind;     // [6:5]
      logic rsvd;           // [4] is zero
      logic [3:0] rmIdx;
    } immShiftView;
    struct packed {
      logic [3:0] rsIdx;
      logic zero;
      shiftKind_t kind;
      logic one;            // [4] is one
      logic [3:0] rmIdx;
    } regShiftView;
    struct packed {
      logic [3:0] rotate;   // Rotate by twice this
      logic [7:0] imm8;
    } rotImmView;
  } shiftField_t;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flags_t;

  typedef struct packed {
    aluOp_t aluOp;
    operandForm_t form;
    logic setFlags;
    shiftField_t field;
    logic [31:0] rn;
    logic [31:0] rm;
    logic [31:0] rs;
  } execOp_t;

  typedef struct packed {
    logic [31:0] value;
    logic writeEn;  // Low for compare/test ops
    flags_t flags;
  } opResult_t;

endpackage

`default_nettype wire

// ==== design/opQueue.sv ====
`default_nettype none

module opQueue (
  input  logic clk,
  input  logic isLDRSTR_shift,
  input  logic opValid,
  input  execPkg::execOp_t op,
  input  logic pop,
  output execPkg::execOp_t head,
  output logic notEmpty,
  output logic inCredit
);

  execPkg::execOp_t entries [execPkg::queueDepth];
  execPkg::qPtr_t wrPtr;
  execPkg::qPtr_t rdPtr;
  execPkg::qCount_t count;

  localparam execPkg::qPtr_t lastSlot = execPkg::qPtr_t'(execPkg::queueDepth - 1);

  assign head = entries[rdPtr];
  assign notEmpty = (count != '0);

  always_ff @(posedge clk) begin
    if (opValid) begin
      entries[wrPtr] <= op; // Upstream holds a credit
    end
  end

  always_ff @(posedge clk) begin
    if (isLDRSTR_shift) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
      inCredit <= 1'b0;
    end else begin
      inCredit <= pop; // One credit back per pop
      if (opValid) begin
        wrPtr <= (wrPtr == lastSlot) ? '0 : wrPtr + 1'b1;
      end
      if (pop) begin
        rdPtr <= (rdPtr == lastSlot) ? '0 : rdPtr + 1'b1;
      end
      case ({opValid, pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count; // Idle or push and pop together
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== design/shifter.sv ====
`default_nettype none

module shifter (
  input  execPkg::operandForm_t form,
  input  execPkg::shiftField_t field,
  input  logic [31:0] rm,
  input  logic [31:0] rs,
  input  logic carryIn,
  output logic [31:0] shifted,
  output logic shiftCarry
);

  logic [32:0] immRes;   // {carry, value}
  logic [32:0] regRes;
  logic [32:0] rotRes;
  logic [4:0] immAmt;
  logic [7:0] regAmt;
  execPkg::shiftKind_t immKind;
  execPkg::shiftKind_t regKind;

  // Returns {carry, value}
  function automatic logic [32:0] shiftOp(input execPkg::shiftKind_t kind,
                                          input logic [31:0] value,
                                          input logic [7:0] amount);
    logic [63:0] rotated;
    logic [32:0] wide;
    logic [32:0] result;
    rotated = {value, value} >> amount[4:0];
    wide = '0;
    case (kind)
      execPkg::lsl: begin
        result = {1'b0, value} << amount; // Carry lands in bit 32
      end
      execPkg::lsr: begin
        wide = {value, 1'b0} >> amount;
        result = {wide[0], wide[32:1]};
      end
      execPkg::asr: begin
        wide = $signed({value, 1'b0}) >>> amount; // Sign fill past 32 too
        result = {wide[0], wide[32:1]};
      end
      default: begin
        if (amount[4:0] == 5'd0) begin
          result = {value[31], value}; // Multiple of 32
        end else begin
          result = {rotated[31], rotated[31:0]};
        end
      end
    endcase
    return result;
  endfunction

  assign immAmt = field.immShiftView.amount;
  assign immKind = field.immShiftView.kind;
  assign regAmt = rs[7:0];
  assign regKind = field.regShiftView.kind;

  always_comb begin
    if (immAmt != 5'd0) begin
      immRes = shiftOp(immKind, rm, {3'b000, immAmt});
    end else begin
      case (immKind)
        execPkg::lsl: immRes = {carryIn, rm};  // Plain move
        execPkg::lsr: immRes = shiftOp(execPkg::lsr, rm, 8'd32);
        execPkg::asr: immRes = shiftOp(execPkg::asr, rm, 8'd32);
        default: immRes = {rm[0], carryIn, rm[31:1]}; // RRX
      endcase
    end
  end

  always_comb begin
    if (regAmt == 8'd0) begin
      regRes = {carryIn, rm};
    end else begin
      regRes = shiftOp(regKind, rm, regAmt);
    end
  end

  always_comb begin
    rotRes = shiftOp(execPkg::ror, {24'h0, field.rotImmView.imm8},
                     {3'b000, field.rotImmView.rotate, 1'b0});
    if (field.rotImmView.rotate == 4'd0) begin
      rotRes[32] = carryIn;
    end
  end

  always_comb begin
    case (form)
      execPkg::immShift: begin
        shifted = immRes[31:0];
        shiftCarry = immRes[32];
      end
      execPkg::regShift: begin
        shifted = regRes[31:0];
        shiftCarry = regRes[32];
      end
      execPkg::memOffset: begin
        shifted = immRes[31:0];
        shiftCarry = 1'b0; // Offsets force C low
      end
      default: begin
        shifted = rotRes[31:0];
        shiftCarry = rotRes[32];
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== design/aluFlags.sv ====
`default_nettype none

module aluFlags (
  input  execPkg::aluOp_t aluOp,
  input  logic setFlags,
  input  logic [31:0] rn,
  input  logic [31:0] operand2,
  input  logic shiftCarry,
  input  execPkg::flags_t curFlags,
  output execPkg::opResult_t nextResult
);

  logic [31:0] addA;
  logic [31:0] addB;
  logic addCin;
  logic [32:0] sum;
  logic overflow;
  logic isArith;
  logic [31:0] value;

  // Operand select for the shared adder
  always_comb begin
    addA = rn;
    addB = operand2;
    addCin = 1'b0;
    isArith = 1'b1;
    case (aluOp)
      execPkg::opSub, execPkg::opCmp: begin
        addB = ~operand2;
        addCin = 1'b1;
      end
      execPkg::opRsb: begin
        addA = operand2;
        addB = ~rn;
        addCin = 1'b1;
      end
      execPkg::opAdc: addCin = curFlags.c;
      execPkg::opSbc: begin
        addB = ~operand2;
        addCin = curFlags.c;
      end
      execPkg::opRsc: begin
        addA = operand2;
        addB = ~rn;
        addCin = curFlags.c;
      end
      execPkg::opAdd, execPkg::opCmn: addCin = 1'b0;
      default: isArith = 1'b0;
    endcase
  end

  assign sum = {1'b0, addA} + {1'b0, addB} + {32'h0, addCin};
  assign overflow = (addA[31] == addB[31]) && (sum[31] != addA[31]);

  always_comb begin
    case (aluOp)
      execPkg::opAnd, execPkg::opTst: value = rn & operand2;
      execPkg::opEor, execPkg::opTeq: value = rn ^ operand2;
      execPkg::opOrr: value = rn | operand2;
      execPkg::opMov: value = operand2;
      execPkg::opBic: value = rn & ~operand2;
      execPkg::opMvn: value = ~operand2;
      default: value = sum[31:0];
    endcase
  end

  always_comb begin
    nextResult.value = value;
    nextResult.writeEn = !(aluOp inside {execPkg::opTst, execPkg::opTeq,
                                         execPkg::opCmp, execPkg::opCmn});
    nextResult.flags = curFlags;
    if (setFlags) begin
      nextResult.flags.n = value[31];
      nextResult.flags.z = (value == 32'h0);
      nextResult.flags.c = isArith ? sum[32] : shiftCarry; // C is no-borrow on subtract
      nextResult.flags.v = isArith ? overflow : curFlags.v;
    end
  end

endmodule

`default_nettype wire

// ==== design/resultIssue.sv ====
`default_nettype none

module resultIssue (
  input  logic clk,
  input  logic isLDRSTR_shift,
  input  logic notEmpty,
  input  execPkg::opResult_t nextResult,
  input  logic creditReturn,
  output logic pop,
  output execPkg::flags_t curFlags,
  output logic resValid,
  output execPkg::opResult_t res
);

  execPkg::creditCnt_t credits;

  assign pop = notEmpty && (credits != '0); // Hold issue without a credit

  always_ff @(posedge clk) begin
    if (isLDRSTR_shift) begin
      credits <= execPkg::creditCnt_t'(execPkg::outCreditInit);
      curFlags <= '0;
      resValid <= 1'b0;
    end else begin
      resValid <= pop;
      if (pop) begin
        curFlags <= nextResult.flags; // Next op sees new C
      end
      case ({pop, creditReturn})
        2'b10: credits <= credits - 1'b1;
        2'b01: credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      res <= nextResult;
    end
  end

endmodule

`default_nettype wire

// ==== design/execCore.sv ====
`default_nettype none

module execCore (
  input  logic clk,
  input  logic isLDRSTR_shift,
  input  logic opValid,
  input  execPkg::execOp_t op,
  output logic inCredit,
  output logic resValid,
  output execPkg::opResult_t res,
  input  logic creditReturn
);

  execPkg::execOp_t head;
  execPkg::opResult_t nextResult;
  execPkg::flags_t curFlags;
  logic notEmpty;
  logic pop;
  logic [31:0] shifted;
  logic shiftCarry;

  opQueue opQueueInst (
    .clk(clk),
    .isLDRSTR_shift(isLDRSTR_shift),
    .opValid(opValid),
    .op(op),
    .pop(pop),
    .head(head),
    .notEmpty(notEmpty),
    .inCredit(inCredit)
  );

  shifter shifterInst (
    .form(head.form),
    .field(head.field),
    .rm(head.rm),
    .rs(head.rs),
    .carryIn(curFlags.c),
    .shifted(shifted),
    .shiftCarry(shiftCarry)
  );

  aluFlags aluFlagsInst (
    .aluOp(head.aluOp),
    .setFlags(head.setFlags),
    .rn(head.rn),
    .operand2(shifted),
    .shiftCarry(shiftCarry),
    .curFlags(curFlags),
    .nextResult(nextResult)
  );

  resultIssue resultIssueInst (
    .clk(clk),
    .isLDRSTR_shift(isLDRSTR_shift),
    .notEmpty(notEmpty),
    .nextResult(nextResult),
    .creditReturn(creditReturn),
    .pop(pop),
    .curFlags(curFlags),
    .resValid(resValid),
    .res(res)
  );

endmodule

`default_nettype wire

// ==== bench/execCore_assertions.sv ====
`default_nettype none

module execCoreAssertions (
  input logic clk,
  input logic isLDRSTR_shift,
  input logic opValid,
  input logic creditReturn,
  input logic resValid,
  input logic inCredit,
  input execPkg::opResult_t res
);
  timeunit 1ns;
  timeprecision 1ps;

  int heldCredits; // Output credits as the consumer counts them
  int inFlight;    // Ops accepted and not yet credited back

  always_ff @(posedge clk) begin
    if (isLDRSTR_shift) begin
      heldCredits <= execPkg::outCreditInit;
      inFlight <= 0;
    end else begin
      heldCredits <= heldCredits - int'(resValid) + int'(creditReturn);
      inFlight <= inFlight + int'(opValid) - int'(inCredit);
    end
  end

  // A credit returned at the pop edge itself is not yet usable
  issueNeedsCredit: assert property (@(posedge clk) disable iff (isLDRSTR_shift)
    resValid |-> heldCredits > int'($past(creditReturn)))
    else $error("result issued with no output credit");

  creditWithPop: assert property (@(posedge clk) disable iff (isLDRSTR_shift)
    inCredit == resValid)
    else $error("input credit and pop out of step");

  creditForOp: assert property (@(posedge clk) disable iff (isLDRSTR_shift)
    inCredit |-> inFlight > 0)
    else $error("input credit with no op accepted");

  resKnown: assert property (@(posedge clk) disable iff (isLDRSTR_shift)
    resValid |-> !$isunknown(res))
    else $error("unknown bits on res while valid");

  quietAfterReset: assert property (@(posedge clk)
    $fell(isLDRSTR_shift) |-> !resValid && !inCredit)
    else $error("outputs active right after reset");

endmodule

bind execCore execCoreAssertions checks (
  .clk(clk),
  .isLDRSTR_shift(isLDRSTR_shift),
  .opValid(opValid),
  .creditReturn(creditReturn),
  .resValid(resValid),
  .inCredit(inCredit),
  .res(res)
);

`default_nettype wire

// ==== bench/execCoreTb.sv ====
`default_nettype none

module execCoreTb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int numRows = 22;
  localparam int waitLimit = 400; // Cycles per wait

  logic clk;
  logic isLDRSTR_shift;
  logic opValid;
  execPkg::execOp_t op;
  logic inCredit;
  logic resValid;
  execPkg::opResult_t res;
  logic creditReturn;

  execPkg::execOp_t rowOp [numRows];
  execPkg::opResult_t rowExp [numRows];
  logic rowStall [numRows];
  int rowCount;

  int upCredits;
  int txIdx;
  int rxIdx;
  int pending;  // Credits owed to the DUT
  int quiet;    // Cycles since last result
  int errors;
  int stallResults;
  int stallSent;
  int t;
  logic running;
  logic stalled;
  logic stallSeen;

  execCore UUT (
    .clk(clk),
    .isLDRSTR_shift(isLDRSTR_shift),
    .opValid(opValid),
    .op(op),
    .inCredit(inCredit),
    .resValid(resValid),
    .res(res),
    .creditReturn(creditReturn)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic execPkg::shiftField_t shiftImm(input logic [4:0] amount,
                                                    input execPkg::shiftKind_t kind);
    execPkg::shiftField_t f;
    f = '0;
    f.immShiftView.amount = amount;
    f.immShiftView.kind = kind;
    return f;
  endfunction

  function automatic execPkg::shiftField_t shiftReg(input execPkg::shiftKind_t kind);
    execPkg::shiftField_t f;
    f = '0;
    f.regShiftView.kind = kind;
    f.regShiftView.one = 1'b1;
    return f;
  endfunction

  function automatic execPkg::shiftField_t rotField(input logic [3:0] rotate,
                                                    input logic [7:0] imm8);
    execPkg::shiftField_t f;
    f.rotImmView.rotate = rotate;
    f.rotImmView.imm8 = imm8;
    return f;
  endfunction

  task automatic addRow(input execPkg::aluOp_t aluOp, input execPkg::operandForm_t form,
                        input logic setFlags, input execPkg::shiftField_t field,
                        input logic [31:0] rn, input logic [31:0] rm, input logic [31:0] rs,
                        input logic [31:0] value, input logic writeEn,
                        input execPkg::flags_t flags, input logic stall);
    rowOp[rowCount].aluOp = aluOp;
    rowOp[rowCount].form = form;
    rowOp[rowCount].setFlags = setFlags;
    rowOp[rowCount].field = field;
    rowOp[rowCount].rn = rn;
    rowOp[rowCount].rm = rm;
    rowOp[rowCount].rs = rs;
    rowExp[rowCount].value = value;
    rowExp[rowCount].writeEn = writeEn;
    rowExp[rowCount].flags = flags;
    rowStall[rowCount] = stall;
    rowCount = rowCount + 1;
  endtask

  // Expected flags are nzcv after each row in table order
  task automatic buildTable();
    addRow(execPkg::opMov, execPkg::immShift, 1, shiftImm(4, execPkg::lsl),
           0, 32'h12345678, 0, 32'h23456780, 1, 4'b0010, 0);
    addRow(execPkg::opMov, execPkg::immShift, 1, shiftImm(8, execPkg::lsr),
           0, 32'h800000F0, 0, 32'h00800000, 1, 4'b0010, 0);
    addRow(execPkg::opMov, execPkg::immShift, 1, shiftImm(4, execPkg::asr),
           0, 32'h80000008, 0, 32'hF8000000, 1, 4'b1010, 0);
    addRow(execPkg::opMov, execPkg::immShift, 1, shiftImm(8, execPkg::ror),
           0, 32'h000000A5, 0, 32'hA5000000, 1, 4'b1010, 0);
    addRow(execPkg::opMov, execPkg::immShift, 1, shiftImm(0, execPkg::lsr),
           0, 32'h80000001, 0, 32'h00000000, 1, 4'b0110, 0); // LSR #32
    addRow(execPkg::opMov, execPkg::immShift, 1, shiftImm(0, execPkg::asr),
           0, 32'h80000000, 0, 32'hFFFFFFFF, 1, 4'b1010, 0); // ASR #32
    addRow(execPkg::opMov, execPkg::immShift, 1, shiftImm(0, execPkg::ror),
           0, 32'h00000003, 0, 32'h80000001, 1, 4'b1010, 0); // RRX
    addRow(execPkg::opMov, execPkg::regShift, 1, shiftReg(execPkg::lsl),
           0, 32'h00000010, 32'd0, 32'h00000010, 1, 4'b0010, 0);
    addRow(execPkg::opMov, execPkg::regShift, 1, shiftReg(execPkg::lsl),
           0, 32'h08000001, 32'd5, 32'h00000020, 1, 4'b0010, 1);
    addRow(execPkg::opMov, execPkg::regShift, 1, shiftReg(execPkg::lsr),
           0, 32'h80000000, 32'd32, 32'h00000000, 1, 4'b0110, 0);
    addRow(execPkg::opMov, execPkg::regShift, 1, shiftReg(execPkg::lsl),
           0, 32'hFFFFFFFF, 32'd33, 32'h00000000, 1, 4'b0100, 0);
    addRow(execPkg::opMov, execPkg::regShift, 1, shiftReg(execPkg::asr),
           0, 32'h80000000, 32'h1C8, 32'hFFFFFFFF, 1, 4'b1010, 0); // Low byte is 200
    addRow(execPkg::opMov, execPkg::regShift, 1, shiftReg(execPkg::ror),
           0, 32'h70000001, 32'd32, 32'h70000001, 1, 4'b0000, 0);
    addRow(execPkg::opMov, execPkg::rotImm, 1, rotField(4, 8'hFF),
           0, 0, 0, 32'hFF000000, 1, 4'b1010, 0);
    addRow(execPkg::opMov, execPkg::rotImm, 1, rotField(0, 8'h2A),
           0, 0, 0, 32'h0000002A, 1, 4'b0010, 0);
    addRow(execPkg::opMov, execPkg::memOffset, 1, shiftImm(2, execPkg::lsl),
           0, 32'hC0000003, 0, 32'h0000000C, 1, 4'b0000, 0); // C was set before
    addRow(execPkg::opAdd, execPkg::immShift, 1, shiftImm(0, execPkg::lsl),
           32'h7FFFFFFF, 32'h00000001, 0, 32'h80000000, 1, 4'b1001, 0);
    addRow(execPkg::opSub, execPkg::immShift, 1, shiftImm(0, execPkg::lsl),
           32'h00000001, 32'h00000002, 0, 32'hFFFFFFFF, 1, 4'b1000, 0); // Borrow
    addRow(execPkg::opCmp, execPkg::immShift, 1, shiftImm(0, execPkg::lsl),
           32'h00000005, 32'h00000003, 0, 32'h00000002, 0, 4'b0010, 0);
    addRow(execPkg::opAdc, execPkg::immShift, 1, shiftImm(0, execPkg::lsl),
           32'hFFFFFFFF, 32'h00000000, 0, 32'h00000000, 1, 4'b0110, 0);
    addRow(execPkg::opAdd, execPkg::immShift, 0, shiftImm(0, execPkg::lsl),
           32'h00000010, 32'h00000020, 0, 32'h00000030, 1, 4'b0110, 0);
    addRow(execPkg::opSub, execPkg::immShift, 1, shiftImm(0, execPkg::lsl),
           32'h80000000, 32'h00000001, 0, 32'h7FFFFFFF, 1, 4'b0011, 0);
  endtask

  task automatic checkResult(input execPkg::opResult_t expected,
                             input execPkg::opResult_t actual, output logic ok);
    ok = 1'b1;
    if (actual.value !== expected.value) begin
      $display("error res.value expected %h got %h", expected.value, actual.value);
      ok = 1'b0;
    end
    if (actual.writeEn !== expected.writeEn) begin
      $display("error res.writeEn expected %h got %h", expected.writeEn, actual.writeEn);
      ok = 1'b0;
    end
  endtask

  task automatic checkFlags(input execPkg::flags_t expected, input execPkg::flags_t actual,
                            output logic ok);
    ok = 1'b1;
    if (actual !== expected) begin
      $display("error res.flags expected %h got %h", expected, actual);
      ok = 1'b0;
    end
  endtask

  task automatic finishRun();
    $display("rows checked %0d of %0d, errors %0d", rxIdx, rowCount, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  endtask

  task automatic expire(input string what);
    $display("timeout: %s", what);
    errors = errors + 1;
  endtask

  // Upstream sender, consumer and result checker on the falling edge
  always @(negedge clk) begin : monitor
    logic valueOk;
    logic flagsOk;
    if (running) begin
      if (inCredit) begin
        upCredits = upCredits + 1;
      end
      creditReturn = 1'b0;
      if (!stalled && pending > 0) begin
        creditReturn = 1'b1;
        pending = pending - 1;
      end
      quiet = resValid ? 0 : quiet + 1;
      if (resValid) begin
        if (rxIdx >= rowCount) begin
          $display("a result arrived after the last row");
          errors = errors + 1;
        end else begin
          checkResult(rowExp[rxIdx], res, valueOk);
          checkFlags(rowExp[rxIdx].flags, res.flags, flagsOk);
          if (!(valueOk && flagsOk)) begin
            errors = errors + 1;
          end
          $display("row %0d %s", rxIdx, (valueOk && flagsOk) ? "ok" : "mismatch");
        end
        rxIdx = rxIdx + 1;
        pending = pending + 1;
        if (stalled) begin
          stallResults = stallResults + 1;
        end
      end
      opValid = 1'b0;
      if (txIdx < rowCount) begin
        if (rowStall[txIdx] && !stallSeen) begin
          stalled = 1'b1; // Consumer holds credits from here
          stallSeen = 1'b1;
        end
        if (upCredits > 0) begin
          op = rowOp[txIdx];
          opValid = 1'b1;
          upCredits = upCredits - 1;
          txIdx = txIdx + 1;
          if (stalled) begin
            stallSent = stallSent + 1;
          end
        end
      end
    end
  end

  initial begin
    isLDRSTR_shift = 1'b1;
    opValid = 1'b0;
    op = '0;
    creditReturn = 1'b0;
    running = 1'b0;
    stalled = 1'b0;
    stallSeen = 1'b0;
    upCredits = execPkg::queueDepth;
    txIdx = 0;
    rxIdx = 0;
    pending = 0;
    quiet = 0;
    errors = 0;
    stallResults = 0;
    stallSent = 0;
    rowCount = 0;
    buildTable();
    repeat (5) @(negedge clk);
    isLDRSTR_shift = 1'b0;
    @(posedge clk);
    running = 1'b1;

    t = 0;
    while (!stalled && t < waitLimit) begin
      @(posedge clk);
      t = t + 1;
    end
    if (!stalled) begin
      expire("the consumer stall never started");
    end else begin
      t = 0;
      while (!(upCredits == 0 && quiet >= 4) && t < waitLimit) begin
        @(posedge clk);
        t = t + 1;
      end
      if (!(upCredits == 0 && quiet >= 4)) begin
        expire("upstream never ran out of credits in the stall");
      end else begin
        if (stallResults > execPkg::outCreditInit) begin
          $display("%0d results were issued while credits were withheld", stallResults);
          errors = errors + 1;
        end
        if (stallSent > execPkg::queueDepth + stallResults) begin
          $display("upstream sent %0d ops in the stall, more than the queue holds", stallSent);
          errors = errors + 1;
        end
        stalled = 1'b0;

        t = 0;
        while (rxIdx < rowCount && t < waitLimit) begin
          @(posedge clk);
          t = t + 1;
        end
        if (rxIdx < rowCount) begin
          expire("not every row produced a result");
        end else begin
          t = 0;
          while (quiet < 4 && t < waitLimit) begin
            @(posedge clk);
            t = t + 1;
          end
          if (quiet < 4) begin
            expire("results kept arriving after the last row");
          end
        end
      end
    end
    finishRun();
  end

endmodule

`default_nettype wire

// ==== list.f ====
design/execPkg.sv
design/opQueue.sv
design/shifter.sv
design/aluFlags.sv
design/resultIssue.sv
design/execCore.sv
bench/execCore_assertions.sv
bench/execCoreTb.sv

// ==== Bender.yml ====
package:
  name: exec_core

sources:
  - design/execPkg.sv
  - design/opQueue.sv
  - design/shifter.sv
  - design/aluFlags.sv
  - design/resultIssue.sv
  - design/execCore.sv
  - target: simulation
    files:
      - bench/execCore_assertions.sv
      - bench/execCoreTb.sv
